//--- hdl/spike_cfg_pkg.sv
// Compile-time sizes; LINE_DEPTH is a power of two and img_size - 2 must fit in IMG_WIDTH.
`default_nettype none

package spike_cfg_pkg;

    // Spike encoding.
    localparam int TIME_STEPS = 4;   // Time steps per pixel.
    localparam int PSUM_W     = 12;  // Signed partial sum width.
    localparam int THR_W      = 12;  // Unsigned firing threshold width.

    // Line geometry.
    localparam int IMG_WIDTH  = 16;  // Maximum pixels per line.
    localparam int SIZE_W     = 10;  // Configured image size width.
    localparam int LINE_W     = IMG_WIDTH * TIME_STEPS;

    // Line store.
    localparam int LINE_DEPTH = 8;
    localparam int IDX_W      = $clog2(LINE_DEPTH);
    localparam int CNT_W      = 8;   // Completed-line counter that wraps.

endpackage

`default_nettype wire

//--- hdl/spike_cmd_pkg.sv
// Command words are 24 bits with the opcode in the top two bits of every layout.
`default_nettype none

package spike_cmd_pkg;

    localparam int CMD_W = 24;

    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_CFG  = 2'd1,
        OP_READ = 2'd2
    } op_e;

    // Configuration layout.
    typedef struct packed {
        op_e                              op;
        logic [spike_cfg_pkg::SIZE_W-1:0] img_size;
        logic [spike_cfg_pkg::THR_W-1:0]  threshold;
    } cmd_cfg_s;

    // Read layout with the line index in the low bits.
    typedef struct packed {
        op_e                                   op;
        logic [CMD_W-3-spike_cfg_pkg::IDX_W:0] reserved;
        logic [spike_cfg_pkg::IDX_W-1:0]       line_idx;
    } cmd_read_s;

    typedef union packed {
        cmd_cfg_s  cfg;
        cmd_read_s rd;
    } cmd_word_u;

endpackage

`default_nettype wire

//--- hdl/lif_spike_encoder.sv
// No leak and potential restarts at zero for each pixel; a zero threshold never fires.
`timescale 1ns/10ps
`default_nettype none

module lif_spike_encoder (
    input  wire                                        s_clk,
    input  wire                                        s_rst,
    input  wire signed [spike_cfg_pkg::PSUM_W-1:0]     i_psum,
    input  wire                                        i_psum_valid,
    input  wire        [spike_cfg_pkg::THR_W-1:0]      i_threshold,
    output logic       [spike_cfg_pkg::TIME_STEPS-1:0] o_spikes,
    output logic                                       o_spikes_valid
);

    import spike_cfg_pkg::*;

    // Four spare bits hold TIME_STEPS accumulations of a negative sum.
    logic signed [PSUM_W+3:0] thr_ext;
    logic signed [PSUM_W+3:0] pot;
    logic [TIME_STEPS-1:0]    spk_next;

    assign thr_ext = $signed({{(PSUM_W + 4 - THR_W){1'b0}}, i_threshold});

    // All time steps unrolled in one cycle.
    always_comb begin
        pot      = '0;
        spk_next = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            pot = pot + i_psum;  // Integrate.
            if ((i_threshold != '0) && (pot >= thr_ext)) begin
                spk_next[t] = 1'b1;
                pot         = pot - thr_ext;  // Soft reset.
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_spikes_valid <= 1'b0;
        end else begin
            o_spikes_valid <= i_psum_valid;
        end
    end

    // Bit t of the spike vector is time step t.
    always_ff @(posedge s_clk) begin
        if (i_psum_valid) begin
            o_spikes <= spk_next;
        end
    end

endmodule

`default_nettype wire

//--- hdl/line_organizer.sv
// Pixels are dropped while img_size is below 3; img_size - 2 must not exceed IMG_WIDTH.
`timescale 1ns/10ps
`default_nettype none

module line_organizer (
    input  wire                                        s_clk,
    input  wire                                        s_rst,
    input  wire                                        i_cfg_load,
    input  wire        [spike_cfg_pkg::SIZE_W-1:0]     i_img_size,
    input  wire        [spike_cfg_pkg::TIME_STEPS-1:0] i_spikes,
    input  wire                                        i_spikes_valid,
    output logic                                       o_line_valid,
    output logic       [spike_cfg_pkg::LINE_W-1:0]     o_line
);

    import spike_cfg_pkg::*;

    logic [SIZE_W-1:0] pix_cnt;   // Position within the current row.
    logic [LINE_W-1:0] line_q;
    logic              cfg_ok;
    logic              pix_en;
    logic              pix_last;

    assign cfg_ok   = (i_img_size >= SIZE_W'(3));
    assign pix_en   = i_spikes_valid && cfg_ok;
    assign pix_last = (pix_cnt == i_img_size - SIZE_W'(3));  // Valid 3x3 width minus one.
    assign o_line   = line_q;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            pix_cnt <= '0;
        end else if (i_cfg_load) begin
            pix_cnt <= '0;
        end else if (pix_en) begin
            pix_cnt <= pix_last ? '0 : pix_cnt + 1'b1;
        end
    end

    // One-cycle pulse once the last pixel of the row is placed.
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_line_valid <= 1'b0;
        end else begin
            o_line_valid <= pix_en && pix_last && !i_cfg_load;
        end
    end

    // Slice k takes pixel k. Pixel 0 also zeroes every higher slice.
    always_ff @(posedge s_clk) begin
        if (pix_en) begin
            for (int k = 0; k < IMG_WIDTH; k++) begin
                if (pix_cnt == SIZE_W'(k)) begin
                    line_q[k*TIME_STEPS +: TIME_STEPS] <= i_spikes;
                end else if (pix_cnt == '0) begin
                    line_q[k*TIME_STEPS +: TIME_STEPS] <= '0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/line_store.sv
// Ring of LINE_DEPTH lines; a clear drops any write in the same cycle and unwritten slots read zero.
`timescale 1ns/10ps
`default_nettype none

module line_store (
    input  wire                                    s_clk,
    input  wire                                    s_rst,
    input  wire                                    i_clear,
    input  wire                                    i_wr_valid,
    input  wire  [spike_cfg_pkg::LINE_W-1:0]       i_wr_line,
    input  wire                                    i_rd_en,
    input  wire  [spike_cfg_pkg::IDX_W-1:0]        i_rd_idx,
    output logic [spike_cfg_pkg::LINE_W-1:0]       o_rd_line,
    output logic                                   o_line_done,
    output logic [spike_cfg_pkg::CNT_W-1:0]        o_line_count
);

    import spike_cfg_pkg::*;

    logic [LINE_W-1:0]     mem [LINE_DEPTH];
    logic [LINE_DEPTH-1:0] written;  // Slot holds a line since the last clear.
    logic [IDX_W-1:0]      wr_ptr;
    logic                  wr_en;

    assign wr_en = i_wr_valid && !i_clear;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            written      <= '0;
            wr_ptr       <= '0;
            o_line_count <= '0;
            o_line_done  <= 1'b0;
        end else if (i_clear) begin
            written      <= '0;
            wr_ptr       <= '0;
            o_line_count <= '0;
            o_line_done  <= 1'b0;
        end else begin
            o_line_done <= i_wr_valid;
            if (i_wr_valid) begin
                written[wr_ptr] <= 1'b1;
                wr_ptr          <= wr_ptr + 1'b1;        // Wraps at LINE_DEPTH.
                o_line_count    <= o_line_count + 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_wr_line;
        end
    end

    // Registered read.
    always_ff @(posedge s_clk) begin
        if (i_rd_en) begin
            o_rd_line <= written[i_rd_idx] ? mem[i_rd_idx] : '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/cmd_ctrl.sv
// Four-phase port with a registered request; the host holds the word while i_cmd_req is high.
`timescale 1ns/10ps
`default_nettype none

module cmd_ctrl (
    input  wire                                  s_clk,
    input  wire                                  s_rst,
    input  wire                                  i_cmd_req,
    input  wire spike_cmd_pkg::cmd_word_u        i_cmd_word,
    output logic                                 o_cmd_ack,
    output logic [spike_cfg_pkg::LINE_W-1:0]     o_rsp_line,
    output logic                                 o_cfg_load,
    output logic [spike_cfg_pkg::SIZE_W-1:0]     o_img_size,
    output logic [spike_cfg_pkg::THR_W-1:0]      o_threshold,
    output logic                                 o_rd_en,
    output logic [spike_cfg_pkg::IDX_W-1:0]      o_rd_idx,
    input  wire  [spike_cfg_pkg::LINE_W-1:0]     i_rd_line
);

    import spike_cmd_pkg::*;

    typedef enum logic [1:0] {IDLE, READ_WAIT, ACK, RELEASE} state_e;

    state_e state;
    logic   req_q;    // Request as seen by the FSM.
    logic   accept;
    logic   is_cfg;
    logic   is_read;

    // Op shares its position in both layouts.
    assign is_cfg    = (i_cmd_word.cfg.op == OP_CFG);
    assign is_read   = (i_cmd_word.rd.op == OP_READ);
    assign accept    = (state == IDLE) && req_q;
    assign o_rd_en   = accept && is_read;  // Store answers one cycle later.
    assign o_rd_idx  = i_cmd_word.rd.line_idx;
    assign o_cmd_ack = (state == ACK);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state       <= IDLE;
            req_q       <= 1'b0;
            o_cfg_load  <= 1'b0;
            o_img_size  <= '0;
            o_threshold <= '0;
        end else begin
            req_q      <= i_cmd_req;
            o_cfg_load <= accept && is_cfg;
            if (accept && is_cfg) begin
                o_img_size  <= i_cmd_word.cfg.img_size;
                o_threshold <= i_cmd_word.cfg.threshold;
            end
            case (state)
                IDLE:      if (req_q) state <= is_read ? READ_WAIT : ACK;
                READ_WAIT: state <= ACK;
                ACK:       if (!req_q) state <= RELEASE;  // Ack falls here.
                RELEASE:   state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // Store data for reads and zero for every other op.
    always_ff @(posedge s_clk) begin
        if (accept) begin
            o_rsp_line <= '0;
        end else if (state == READ_WAIT) begin
            o_rsp_line <= i_rd_line;
        end
    end

endmodule

`default_nettype wire

//--- hdl/spike_line_top.sv
// Pixel stream has no ready; do not send pixels while a configuration command is in progress.
`timescale 1ns/10ps
`default_nettype none

module spike_line_top (
    input  wire                                    s_clk,
    input  wire                                    s_rst,
    input  wire signed [spike_cfg_pkg::PSUM_W-1:0] i_psum,
    input  wire                                    i_psum_valid,
    input  wire                                    i_cmd_req,
    input  wire spike_cmd_pkg::cmd_word_u          i_cmd_word,
    output logic                                   o_cmd_ack,
    output logic [spike_cfg_pkg::LINE_W-1:0]       o_rsp_line,
    output logic                                   o_line_done,
    output logic [spike_cfg_pkg::CNT_W-1:0]        o_line_count
);

    import spike_cfg_pkg::*;

    logic [TIME_STEPS-1:0] spikes;
    logic                  spikes_valid;
    logic                  line_valid;
    logic [LINE_W-1:0]     line;
    logic                  cfg_load;  // Also clears the store.
    logic [SIZE_W-1:0]     img_size;
    logic [THR_W-1:0]      threshold;
    logic                  rd_en;
    logic [IDX_W-1:0]      rd_idx;
    logic [LINE_W-1:0]     rd_line;

    lif_spike_encoder u_encoder (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_psum         (i_psum),
        .i_psum_valid   (i_psum_valid),
        .i_threshold    (threshold),
        .o_spikes       (spikes),
        .o_spikes_valid (spikes_valid)
    );

    line_organizer u_organizer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_cfg_load     (cfg_load),
        .i_img_size     (img_size),
        .i_spikes       (spikes),
        .i_spikes_valid (spikes_valid),
        .o_line_valid   (line_valid),
        .o_line         (line)
    );

    line_store u_store (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_clear      (cfg_load),
        .i_wr_valid   (line_valid),
        .i_wr_line    (line),
        .i_rd_en      (rd_en),
        .i_rd_idx     (rd_idx),
        .o_rd_line    (rd_line),
        .o_line_done  (o_line_done),
        .o_line_count (o_line_count)
    );

    cmd_ctrl u_cmd (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_cmd_req   (i_cmd_req),
        .i_cmd_word  (i_cmd_word),
        .o_cmd_ack   (o_cmd_ack),
        .o_rsp_line  (o_rsp_line),
        .o_cfg_load  (cfg_load),
        .o_img_size  (img_size),
        .o_threshold (threshold),
        .o_rd_en     (rd_en),
        .o_rd_idx    (rd_idx),
        .i_rd_line   (rd_line)
    );

endmodule

`default_nettype wire

//--- test/tb_spike_line_checks.svh
// Included in tb_spike_line after its signals; tasks block on s_clk and stop at the first error.
`ifndef TB_SPIKE_LINE_CHECKS_SVH
`define TB_SPIKE_LINE_CHECKS_SVH

task automatic abort_run(input string why);
    failed = 1'b1;
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
endtask

task automatic check_line(input string what, input logic [LINE_W-1:0] exp,
                          input logic [LINE_W-1:0] act);
    if (act !== exp) begin
        abort_run($sformatf("Fail %s %s: expected %h actual %h", test_name, what, exp, act));
    end
endtask

task automatic check_count(input string what, input logic [CNT_W-1:0] exp,
                           input logic [CNT_W-1:0] act);
    if (act !== exp) begin
        abort_run($sformatf("Fail %s %s: expected %0d actual %0d", test_name, what, exp, act));
    end
endtask

task automatic check_word(input string what, input cmd_word_u exp, input cmd_word_u act);
    if (act !== exp) begin
        abort_run($sformatf("Fail %s %s: expected %h actual %h", test_name, what, exp, act));
    end
endtask

task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        abort_run($sformatf("Fail %s %s: expected %b actual %b", test_name, what, exp, act));
    end
endtask

// Full four-phase exchange. The request stays high for hold extra cycles after ack.
task automatic do_cmd(input cmd_word_u word, input int hold, output logic [LINE_W-1:0] line);
    int waited;
    @(posedge s_clk);
    i_cmd_word <= word;
    i_cmd_req  <= 1'b1;
    waited = 0;
    do begin
        @(negedge s_clk);
        waited++;
    end while (!o_cmd_ack && waited < ACK_LIMIT);
    if (!o_cmd_ack) begin
        abort_run($sformatf("%s: no acknowledge within %0d cycles", test_name, ACK_LIMIT));
    end
    line = o_rsp_line;
    repeat (hold) begin
        @(negedge s_clk);
        check_flag("ack held", 1'b1, o_cmd_ack);
        check_line("response held", line, o_rsp_line);
    end
    @(posedge s_clk);
    i_cmd_req <= 1'b0;
    @(negedge s_clk);
    check_flag("ack after request fall", 1'b1, o_cmd_ack);  // Ack must trail the request.
    waited = 0;
    while (o_cmd_ack && waited < ACK_LIMIT) begin
        @(negedge s_clk);
        waited++;
    end
    if (o_cmd_ack) begin
        abort_run($sformatf("%s: acknowledge stayed high after the request fell", test_name));
    end
endtask

task automatic read_line(input int idx, input int hold, output logic [LINE_W-1:0] line);
    cmd_word_u word;
    word             = '0;
    word.rd.op       = OP_READ;
    word.rd.line_idx = IDX_W'(idx);
    do_cmd(word, hold, line);
endtask

`endif

//--- test/tb_spike_line.sv
// Directed tests capped at 4000 cycles; pixels are sent only between commands, never during one.
`timescale 1ns/10ps
`default_nettype none

module tb_spike_line;

    import spike_cfg_pkg::*;
    import spike_cmd_pkg::*;

    localparam int ACK_LIMIT  = 20;
    localparam int MAX_CYCLES = 4000;  // About 45 commands and 16 rows need under 1000.

    logic                     s_clk;
    logic                     s_rst;
    logic signed [PSUM_W-1:0] i_psum;
    logic                     i_psum_valid;
    logic                     i_cmd_req;
    cmd_word_u                i_cmd_word;
    logic                     o_cmd_ack;
    logic [LINE_W-1:0]        o_rsp_line;
    logic                     o_line_done;
    logic [CNT_W-1:0]         o_line_count;

    string             test_name = "init";
    bit                failed;
    int                cycles;
    int                cfg_thr;                  // Threshold the model encodes with.
    int                row_psum [IMG_WIDTH];
    logic [LINE_W-1:0] model_mem [LINE_DEPTH];   // Expected ring contents.
    int                model_ptr;
    int                model_count;
    logic [LINE_W-1:0] rsp;

    spike_line_top u_dut (.*);

    `include "tb_spike_line_checks.svh"

    initial begin
        s_clk = 1'b0;
        forever #10 s_clk = ~s_clk;
    end

    always @(posedge s_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("Timeout in %s after %0d cycles", test_name, MAX_CYCLES));
        end
    end

    // Integrate the sum each step, fire at the threshold and subtract it.
    task automatic model_encode(input int psum, input int thr,
                                output logic [TIME_STEPS-1:0] spk);
        int pot;
        pot = 0;
        spk = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            pot += psum;
            if (thr != 0 && pot >= thr) begin
                spk[t] = 1'b1;
                pot -= thr;
            end
        end
    endtask

    task automatic configure(input int size, input int thr, input int hold);
        cmd_word_u word;
        cmd_word_u echo;
        word               = '0;
        word.cfg.op        = OP_CFG;
        word.cfg.img_size  = SIZE_W'(size);
        word.cfg.threshold = THR_W'(thr);
        do_cmd(word, hold, rsp);
        echo = rsp[CMD_W-1:0];
        check_word("cfg echo", '0, echo);
        check_line("cfg response", '0, rsp);
        cfg_thr     = thr;
        model_ptr   = 0;
        model_count = 0;
        foreach (model_mem[i]) model_mem[i] = '0;
        check_count("count after cfg", '0, o_line_count);
    endtask

    task automatic random_row(input int width);
        for (int k = 0; k < width; k++) begin
            row_psum[k] = int'($urandom % 4096) - 2048;
        end
    endtask

    // Drives one row back to back, then waits for the store write.
    task automatic send_row(input int width);
        logic [LINE_W-1:0]     line;
        logic [TIME_STEPS-1:0] spk;
        int                    waited;
        line = '0;
        for (int k = 0; k < width; k++) begin
            @(posedge s_clk);
            i_psum       <= PSUM_W'(row_psum[k]);
            i_psum_valid <= 1'b1;
            model_encode(row_psum[k], cfg_thr, spk);
            line[k*TIME_STEPS +: TIME_STEPS] = spk;
        end
        @(posedge s_clk);
        i_psum_valid <= 1'b0;
        waited = 0;
        do begin
            @(negedge s_clk);
            waited++;
        end while (!o_line_done && waited < 8);
        if (!o_line_done) begin
            abort_run($sformatf("%s: o_line_done did not pulse after a row", test_name));
        end
        model_mem[model_ptr] = line;
        model_ptr            = (model_ptr + 1) % LINE_DEPTH;
        model_count++;
        check_count("line count", CNT_W'(model_count), o_line_count);
        @(negedge s_clk);
        check_flag("line done pulse", 1'b0, o_line_done);
    endtask

    task automatic check_slots();
        for (int i = 0; i < LINE_DEPTH; i++) begin
            read_line(i, 0, rsp);
            check_line($sformatf("slot %0d", i), model_mem[i], rsp);
        end
    endtask

    initial begin
        cmd_word_u odd_word;
        void'($urandom(72631));
        s_rst        = 1'b1;
        i_psum       = '0;
        i_psum_valid = 1'b0;
        i_cmd_req    = 1'b0;
        i_cmd_word   = '0;
        foreach (model_mem[i]) model_mem[i] = '0;
        repeat (5) @(posedge s_clk);
        s_rst <= 1'b0;

        test_name = "reset";
        @(negedge s_clk);
        check_flag("ack", 1'b0, o_cmd_ack);
        check_flag("line done", 1'b0, o_line_done);
        check_count("line count", '0, o_line_count);
        check_slots();

        test_name = "encode_pack";
        configure(18, 100, 1);
        row_psum = '{0, -5, 100, 2047, 50, 25, -2048, 99, 101, 33, 200, 400, -100, 75, 1, 300};
        send_row(16);
        check_slots();
        check_count("one line", CNT_W'(1), o_line_count);

        test_name = "short_lines";
        configure(8, 150, 0);
        repeat (2) begin
            random_row(6);
            send_row(6);
        end
        for (int i = 0; i < 2; i++) begin
            read_line(i, 0, rsp);
            check_line("upper slices", '0, rsp >> (6 * TIME_STEPS));
            check_line("short line", model_mem[i], rsp);
        end
        check_count("two lines", CNT_W'(2), o_line_count);

        test_name = "ring_wrap";
        configure(6, 100, 0);
        repeat (10) begin
            random_row(4);
            send_row(4);
        end
        check_slots();
        check_count("ten lines", CNT_W'(10), o_line_count);
        odd_word             = '0;  // OP_NONE.
        odd_word.rd.line_idx = IDX_W'(1);
        do_cmd(odd_word, 0, rsp);
        check_line("unknown op", '0, rsp);

        test_name = "cfg_clear";
        configure(6, 100, 0);
        check_slots();

        test_name = "handshake";
        configure(6, 0, 3);
        for (int k = 0; k < 4; k++) begin
            row_psum[k] = 2047 - 500 * k;
        end
        send_row(4);
        read_line(0, 3, rsp);
        check_line("zero threshold", '0, rsp);

        if (!failed) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- spike_line.f
+incdir+test
hdl/spike_cfg_pkg.sv
hdl/spike_cmd_pkg.sv
hdl/lif_spike_encoder.sv
hdl/line_organizer.sv
hdl/line_store.sv
hdl/cmd_ctrl.sv
hdl/spike_line_top.sv
test/tb_spike_line.sv

//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal
TOP        ?= tb_spike_line
RTL_TOP    ?= spike_line_top
FILELIST   ?= spike_line.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
